// File: Makefile
SIM = obj_dir/Vtb_wb_backplane

all: run

$(SIM): wb_backplane.f hdl/*.sv testbench/*.sv
	verilator --binary --timing --assert --top-module tb_wb_backplane \
		-f wb_backplane.f -o Vtb_wb_backplane

run: $(SIM) testbench/backplane_tests.txt
	./$(SIM) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: hdl/backplane_pkg.sv
// shared types and constants of the wishbone backplane
// bus request, device selects, i/o page map and owner encodings

`default_nettype none

package backplane_pkg;

   //****************************************
   // bus widths
   //****************************************
   typedef logic [15:0] addr_t;   // word address on the shared bus
   typedef logic [15:0] data_t;   // data word
   typedef logic [1:0]  sel_t;    // byte lanes, [1] high byte

   // one master's request, cyc doubles as dma bus request
   typedef struct packed {
      logic  cyc;
      logic  stb;
      logic  we;
      sel_t  sel;
      addr_t adr;
      data_t dat;
   } bus_req_t;

   // one bit per slave on the backplane
   typedef struct packed {
      logic ram;
      logic uart1;   // console
      logic uart2;
      logic lpt;     // printer port
      logic rk;
      logic dw;
      logic rx;
      logic my;
      logic kgd;     // graphics
   } dev_sel_t;

   // read data of every slave, same order as dev_sel_t
   typedef struct packed {
      data_t ram;
      data_t uart1;
      data_t uart2;
      data_t lpt;
      data_t rk;
      data_t dw;
      data_t rx;
      data_t my;
      data_t kgd;
   } dev_dat_t;

   // sd card clients
   typedef struct packed {
      logic rk;
      logic dw;
      logic dx;
      logic my;
   } sd_vec_t;

   typedef enum logic [1:0] {OWN_CPU, OWN_RK, OWN_MY} bus_owner_e;
   typedef enum logic [2:0] {SD_NONE, SD_RK, SD_DW, SD_DX, SD_MY} sd_owner_e;

   //****************************************
   // i/o page map
   //****************************************
   localparam addr_t UART1_BASE = 16'o177560;   // 177560-177566
   localparam addr_t UART2_BASE = 16'o176500;   // 176500-176506
   localparam addr_t LPT_BASE   = 16'o177514;   // 177514-177516
   localparam addr_t RK_BASE    = 16'o177400;   // 177400-177416
   localparam addr_t DW_BASE    = 16'o174000;   // 174000-174036
   localparam addr_t RX_BASE    = 16'o177170;   // 177170-177172
   localparam addr_t MY_BASE    = 16'o172140;   // 172140-172142
   localparam addr_t KGD_BASE   = 16'o176640;   // 176640-176646

   localparam logic [2:0] RAM_TOP_BITS = 3'b111;   // top 8k words = i/o page

   // card lines while nobody owns it
   localparam logic SD_IDLE_MOSI = 1'b1;
   localparam logic SD_IDLE_CS   = 1'b1;   // deselected

endpackage

`default_nettype wire

// File: hdl/bus_master_switch.sv
// dma arbiter and master switch of the wishbone backplane
// cpu owns the bus unless rk or my asks for it
// the owner only changes between bus cycles

`default_nettype none

module bus_master_switch (
   input  wire                   wb_clk,
   input  wire                   rst_n_i,
   input  backplane_pkg::bus_req_t cpu_req_i,
   input  backplane_pkg::bus_req_t rk_req_i,    // rk dma
   input  backplane_pkg::bus_req_t my_req_i,    // my dma
   input  wire                   global_ack_i,  // or of all slave acks
   output backplane_pkg::bus_req_t bus_o,       // shared bus
   output logic                  cpu_gnt_o,
   output logic                  rk_gnt_o,
   output logic                  my_gnt_o,
   output logic                  cpu_ack_o,
   output logic                  rk_ack_o,
   output logic                  my_ack_o
);

   import backplane_pkg::*;

   bus_owner_e owner;       // current bus master
   bus_owner_e owner_nxt;

   //****************************************
   // grant state
   //****************************************
   always_comb begin
      owner_nxt = owner;
      if (!bus_o.cyc) begin   // switch only with no cycle running
         if (rk_req_i.cyc) begin
            owner_nxt = OWN_RK;   // rk first
         end else if (my_req_i.cyc) begin
            owner_nxt = OWN_MY;
         end else begin
            owner_nxt = OWN_CPU;  // back to the processor
         end
      end
   end

   always_ff @(posedge wb_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         owner <= OWN_CPU;
      end else begin
         owner <= owner_nxt;
      end
   end

   assign rk_gnt_o  = (owner == OWN_RK);
   assign my_gnt_o  = (owner == OWN_MY);
   assign cpu_gnt_o = ~(rk_gnt_o | my_gnt_o);   // cpu waits while dma runs

   //****************************************
   // request mux
   //****************************************
   always_comb begin
      case (owner)
         OWN_RK: begin
            bus_o     = rk_req_i;
            bus_o.sel = 2'b11;   // dma moves whole words
         end
         OWN_MY: begin
            bus_o     = my_req_i;
            bus_o.sel = 2'b11;
         end
         default: bus_o = cpu_req_i;
      endcase
   end

   // ack goes back to the owner only
   assign cpu_ack_o = cpu_gnt_o & global_ack_i;
   assign rk_ack_o  = rk_gnt_o & global_ack_i;
   assign my_ack_o  = my_gnt_o & global_ack_i;

   a_one_grant: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      $onehot0({cpu_gnt_o, rk_gnt_o, my_gnt_o}));

endmodule

`default_nettype wire

// File: hdl/io_page_decoder.sv
// address decoder of the backplane
// turns the shared bus address into one select per slave, ram below
// the i/o page or wherever the cpu board asks for it

`default_nettype none

module io_page_decoder (
   input  backplane_pkg::bus_req_t bus_i,
   input  wire                   sysram_stb_i,   // cpu board system ram window
   output backplane_pkg::dev_sel_t dev_sel_o
);

   import backplane_pkg::*;

   logic acc;   // valid bus access in progress

   assign acc = bus_i.cyc & bus_i.stb;

   //****************************************
   // i/o page registers
   //****************************************
   always_comb begin
      // 4 registers each
      dev_sel_o.uart1 = acc & (bus_i.adr[15:3] == UART1_BASE[15:3]);
      dev_sel_o.uart2 = acc & (bus_i.adr[15:3] == UART2_BASE[15:3]);
      dev_sel_o.kgd   = acc & (bus_i.adr[15:3] == KGD_BASE[15:3]);

      // 2 registers
      dev_sel_o.lpt = acc & (bus_i.adr[15:2] == LPT_BASE[15:2]);
      dev_sel_o.rx  = acc & (bus_i.adr[15:2] == RX_BASE[15:2]);
      dev_sel_o.my  = acc & (bus_i.adr[15:2] == MY_BASE[15:2]);

      // disk controllers with larger register files
      dev_sel_o.rk = acc & (bus_i.adr[15:4] == RK_BASE[15:4]);   // 8 regs
      dev_sel_o.dw = acc & (bus_i.adr[15:5] == DW_BASE[15:5]);   // 16 regs

      // main memory, 000000-157777 plus the system ram overlay
      dev_sel_o.ram = (acc & (bus_i.adr[15:13] != RAM_TOP_BITS)) | sysram_stb_i;
   end

endmodule

`default_nettype wire

// File: hdl/sd_card_arbiter.sv
// sd card access arbiter
// one card shared by the rk, dw, dx and my disk controllers, fixed
// priority from idle, the owner keeps the card until it drops req

`default_nettype none

module sd_card_arbiter (
   input  wire                  wb_clk,
   input  wire                  rst_n_i,
   input  backplane_pkg::sd_vec_t sd_req_i,    // access requests
   input  backplane_pkg::sd_vec_t sd_mosi_i,   // mosi per controller
   input  backplane_pkg::sd_vec_t sd_cs_i,     // cs per controller
   output backplane_pkg::sd_vec_t sd_gnt_o,
   output logic                 sdcard_mosi_o,
   output logic                 sdcard_cs_o
);

   import backplane_pkg::*;

   sd_owner_e state;
   sd_owner_e state_nxt;
   logic      owner_req;   // req of the controller holding the card

   //****************************************
   // owner fsm
   //****************************************
   assign owner_req = |(sd_req_i & sd_gnt_o);

   always_comb begin
      state_nxt = state;
      if (state == SD_NONE) begin
         // idle, look for a requester
         if (sd_req_i.rk) begin
            state_nxt = SD_RK;
         end else if (sd_req_i.dw) begin
            state_nxt = SD_DW;
         end else if (sd_req_i.dx) begin
            state_nxt = SD_DX;
         end else if (sd_req_i.my) begin
            state_nxt = SD_MY;
         end
      end else if (!owner_req) begin
         state_nxt = SD_NONE;   // released, one idle cycle before next grant
      end
   end

   always_ff @(posedge wb_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state <= SD_NONE;
      end else begin
         state <= state_nxt;
      end
   end

   //****************************************
   // grants and card line mux
   //****************************************
   always_comb begin
      sd_gnt_o      = '0;
      sdcard_mosi_o = SD_IDLE_MOSI;
      sdcard_cs_o   = SD_IDLE_CS;
      case (state)
         SD_RK: begin
            sd_gnt_o.rk   = 1'b1;
            sdcard_mosi_o = sd_mosi_i.rk;
            sdcard_cs_o   = sd_cs_i.rk;
         end
         SD_DW: begin
            sd_gnt_o.dw   = 1'b1;
            sdcard_mosi_o = sd_mosi_i.dw;
            sdcard_cs_o   = sd_cs_i.dw;
         end
         SD_DX: begin
            sd_gnt_o.dx   = 1'b1;
            sdcard_mosi_o = sd_mosi_i.dx;
            sdcard_cs_o   = sd_cs_i.dx;
         end
         SD_MY: begin
            sd_gnt_o.my   = 1'b1;
            sdcard_mosi_o = sd_mosi_i.my;
            sdcard_cs_o   = sd_cs_i.my;
         end
         default: ;   // idle levels
      endcase
   end

   a_gnt_onehot: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      $onehot0(sd_gnt_o));

endmodule

`default_nettype wire

// File: hdl/slave_return.sv
// slave return path of the backplane
// muxes read data of the selected slave, delays the ram completion
// by two clocks and collects all acks into one

`default_nettype none

module slave_return (
   input  wire                   wb_clk,
   input  wire                   rst_n_i,
   input  backplane_pkg::dev_sel_t dev_sel_i,
   input  backplane_pkg::dev_dat_t slave_dat_i,
   input  backplane_pkg::dev_sel_t slave_ack_i,   // ram bit unused
   input  wire                   ram_done_i,    // ram finished read or write
   output backplane_pkg::data_t    dat_o,
   output logic                  global_ack_o
);

   import backplane_pkg::*;

   logic [1:0] ram_dly;   // completion pipe
   logic       ram_ack;
   dev_sel_t   ack_all;

   //****************************************
   // read data mux
   //****************************************
   // selects are one-hot in normal use, so a plain or will do
   assign dat_o = (dev_sel_i.ram   ? slave_dat_i.ram   : '0)
                | (dev_sel_i.uart1 ? slave_dat_i.uart1 : '0)
                | (dev_sel_i.uart2 ? slave_dat_i.uart2 : '0)
                | (dev_sel_i.lpt   ? slave_dat_i.lpt   : '0)
                | (dev_sel_i.rk    ? slave_dat_i.rk    : '0)
                | (dev_sel_i.dw    ? slave_dat_i.dw    : '0)
                | (dev_sel_i.rx    ? slave_dat_i.rx    : '0)
                | (dev_sel_i.my    ? slave_dat_i.my    : '0)
                | (dev_sel_i.kgd   ? slave_dat_i.kgd   : '0);

   //****************************************
   // ram ack delay
   //****************************************
   always_ff @(posedge wb_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ram_dly <= '0;
      end else begin
         ram_dly[0] <= dev_sel_i.ram & ram_done_i;
         ram_dly[1] <= dev_sel_i.ram & ram_dly[0];   // cleared if ram deselected
      end
   end

   assign ram_ack = dev_sel_i.ram & ram_dly[1];   // drops with the select

   // global ack
   always_comb begin
      ack_all     = slave_ack_i;
      ack_all.ram = ram_ack;   // ram answers through the pipe only
   end

   assign global_ack_o = |ack_all;

   // slaves only answer while addressed
   a_ack_needs_sel: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      global_ack_o |-> (|dev_sel_i));

endmodule

`default_nettype wire

// File: hdl/wb_backplane.sv
// wishbone backplane top
// dma master switch, i/o page decoder, slave return path and the
// sd card arbiter of the pdp-11 board

`default_nettype none

module wb_backplane (
   input  wire                   wb_clk,
   input  wire                   rst_n_i,

   // bus masters
   input  backplane_pkg::bus_req_t cpu_req_i,
   input  backplane_pkg::bus_req_t rk_req_i,
   input  backplane_pkg::bus_req_t my_req_i,
   input  wire                   sysram_stb_i,
   output backplane_pkg::bus_req_t bus_o,
   output logic                  cpu_gnt_o,
   output logic                  rk_gnt_o,
   output logic                  my_gnt_o,
   output logic                  cpu_ack_o,
   output logic                  rk_ack_o,
   output logic                  my_ack_o,

   // slaves
   output backplane_pkg::dev_sel_t dev_sel_o,
   input  backplane_pkg::dev_dat_t slave_dat_i,
   input  backplane_pkg::dev_sel_t slave_ack_i,
   input  wire                   ram_done_i,
   output backplane_pkg::data_t    dat_o,

   // sd card
   input  backplane_pkg::sd_vec_t  sd_req_i,
   input  backplane_pkg::sd_vec_t  sd_mosi_i,
   input  backplane_pkg::sd_vec_t  sd_cs_i,
   output backplane_pkg::sd_vec_t  sd_gnt_o,
   output logic                  sdcard_mosi_o,
   output logic                  sdcard_cs_o
);

   logic global_ack;   // or of all slave acks

   //****************************************
   // request path
   //****************************************
   bus_master_switch u_master_switch (
      .wb_clk       (wb_clk),
      .rst_n_i      (rst_n_i),
      .cpu_req_i    (cpu_req_i),
      .rk_req_i     (rk_req_i),
      .my_req_i     (my_req_i),
      .global_ack_i (global_ack),
      .bus_o        (bus_o),
      .cpu_gnt_o    (cpu_gnt_o),
      .rk_gnt_o     (rk_gnt_o),
      .my_gnt_o     (my_gnt_o),
      .cpu_ack_o    (cpu_ack_o),
      .rk_ack_o     (rk_ack_o),
      .my_ack_o     (my_ack_o)
   );

   io_page_decoder u_decoder (
      .bus_i        (bus_o),
      .sysram_stb_i (sysram_stb_i),
      .dev_sel_o    (dev_sel_o)
   );

   // return path
   slave_return u_return (
      .wb_clk       (wb_clk),
      .rst_n_i      (rst_n_i),
      .dev_sel_i    (dev_sel_o),
      .slave_dat_i  (slave_dat_i),
      .slave_ack_i  (slave_ack_i),
      .ram_done_i   (ram_done_i),
      .dat_o        (dat_o),
      .global_ack_o (global_ack)
   );

   //****************************************
   // sd card, independent of the bus
   //****************************************
   sd_card_arbiter u_sd_arbiter (
      .wb_clk        (wb_clk),
      .rst_n_i       (rst_n_i),
      .sd_req_i      (sd_req_i),
      .sd_mosi_i     (sd_mosi_i),
      .sd_cs_i       (sd_cs_i),
      .sd_gnt_o      (sd_gnt_o),
      .sdcard_mosi_o (sdcard_mosi_o),
      .sdcard_cs_o   (sdcard_cs_o)
   );

endmodule

`default_nettype wire

// File: testbench/backplane_tests.txt
// op adr mask exp_sel exp_dat, all hex
// op 1 decode, 2 ram delay, 3 dma both, 4 dma during cpu cycle, 5 sd (adr=req, dat=order)
1 ff70 0007 080 ff71
1 fd40 0007 040 fd42
1 ff4c 0003 020 ff4f
1 ff00 000f 010 ff04
1 f800 001f 008 f805
1 fe78 0003 004 fe7e
1 f460 0003 002 f467
1 fda0 0007 001 fda8
2 1000 0fff 100 1234
2 bffe 0001 100 1234
3 0400 0000 100 0000
4 0800 0000 100 0000
5 000f 0000 000 8421
0 0000 0000 000 0000

// File: testbench/tb_wb_backplane.sv
// testbench of the wishbone backplane
// file driven cpu, dma and sd card scenarios against simple slave models

`default_nettype none

module tb_wb_backplane;

   import backplane_pkg::*;

   localparam int WAIT_LIMIT = 20;
   localparam int NUM_WORDS  = 100;
   // per device tags xor'd onto the base address by the slave models
   localparam data_t RAM_TAG = 16'h1234;
   localparam data_t UART1_TAG = 16'h0001;
   localparam data_t UART2_TAG = 16'h0002;
   localparam data_t LPT_TAG = 16'h0003;
   localparam data_t RK_TAG = 16'h0004;
   localparam data_t DW_TAG = 16'h0005;
   localparam data_t RX_TAG = 16'h0006;
   localparam data_t MY_TAG = 16'h0007;
   localparam data_t KGD_TAG = 16'h0008;

   logic     wb_clk, rst_n_i, sysram_stb_i;
   bus_req_t cpu_req_i, rk_req_i, my_req_i, bus_o;
   logic     cpu_gnt_o, rk_gnt_o, my_gnt_o, cpu_ack_o, rk_ack_o, my_ack_o;
   dev_sel_t dev_sel_o, slave_ack_i;
   dev_dat_t slave_dat_i;
   logic     ram_done_i = 1'b0;
   logic     ram_busy = 1'b0;   // ram model already answered this select
   data_t    dat_o;
   sd_vec_t  sd_req_i, sd_cs_i, sd_gnt_o;
   sd_vec_t  sd_mosi_i = '0;
   logic     sdcard_mosi_o, sdcard_cs_o;

   logic [15:0] vec [0:NUM_WORDS-1];   // five test words per line of the file
   int errors = 0;

   wb_backplane uut (.*);

   initial begin
      wb_clk = 1'b0;
      forever #50 wb_clk = ~wb_clk;
   end

   //****************************************
   // slave models
   //****************************************
   always_comb begin
      slave_dat_i.ram   = RAM_TAG;   // ram sits at base 0
      slave_dat_i.uart1 = UART1_BASE ^ UART1_TAG;
      slave_dat_i.uart2 = UART2_BASE ^ UART2_TAG;
      slave_dat_i.lpt   = LPT_BASE ^ LPT_TAG;
      slave_dat_i.rk    = RK_BASE ^ RK_TAG;
      slave_dat_i.dw    = DW_BASE ^ DW_TAG;
      slave_dat_i.rx    = RX_BASE ^ RX_TAG;
      slave_dat_i.my    = MY_BASE ^ MY_TAG;
      slave_dat_i.kgd   = KGD_BASE ^ KGD_TAG;
      slave_ack_i       = dev_sel_o;   // io slaves answer at once
      slave_ack_i.ram   = 1'b0;
   end

   // ram done pulse one cycle after select
   always @(posedge wb_clk) begin
      ram_done_i <= dev_sel_o.ram & ~ram_busy;
      ram_busy   <= dev_sel_o.ram;
      sd_mosi_i  <= 4'($urandom);   // fresh mosi every clock
   end

   function automatic bus_req_t build_req(input logic cyc, input sel_t sel, input addr_t adr);
      bus_req_t r;
      r.cyc = cyc;
      r.stb = cyc;
      r.we  = 1'b0;
      r.sel = sel;
      r.adr = adr;
      r.dat = '0;
      return r;
   endfunction

   task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
      assert (got == exp) else begin
         errors++;
         $display("ERR %s got %h exp %h", name, got, exp);
      end
   endtask

   task automatic timed_out(input string what);
      errors++;
      $display("timeout while waiting for %s", what);
   endtask

   // 0 cpu, 1 rk, 2 my
   function automatic logic ack_of(input int who);
      return (who == 0) ? cpu_ack_o : (who == 1) ? rk_ack_o : my_ack_o;
   endfunction

   function automatic logic gnt_of(input int who);
      return (who == 0) ? cpu_gnt_o : (who == 1) ? rk_gnt_o : my_gnt_o;
   endfunction

   //****************************************
   // handshake waits
   //****************************************
   task automatic wait_ack(input int who, output int cycles);
      cycles = 0;
      do begin
         @(negedge wb_clk);
         cycles++;
         if (who != 0) check("cpu_ack_o", 16'(cpu_ack_o), 16'h0);
      end while (!ack_of(who) && cycles < WAIT_LIMIT);
      if (!ack_of(who)) timed_out("bus ack");
   endtask

   task automatic wait_gnt(input int who);
      int n;
      n = 0;
      do begin
         @(negedge wb_clk);
         n++;
      end while (!gnt_of(who) && n < WAIT_LIMIT);
      if (!gnt_of(who)) timed_out("bus grant");
   endtask

   // own is the only controller allowed to hold the card meanwhile
   task automatic wait_sd(input logic [3:0] exp, input logic [3:0] own);
      int n;
      n = 0;
      do begin
         @(negedge wb_clk);
         n++;
         if (sd_gnt_o != '0) begin
            check("sd_gnt_o", 16'(sd_gnt_o), 16'(own));
            check("sdcard_mosi_o", 16'(sdcard_mosi_o), 16'(|(sd_mosi_i & own)));
         end else begin
            check("sdcard_mosi_o", 16'(sdcard_mosi_o), 16'(SD_IDLE_MOSI));
         end
      end while (sd_gnt_o != exp && n < WAIT_LIMIT);
      if (sd_gnt_o != exp) timed_out("sd grant change");
   endtask

   //****************************************
   // scenarios
   //****************************************
   task automatic run_decode(input addr_t adr, input logic [15:0] mask,
                             input logic [15:0] sel, input logic [15:0] dat);
      addr_t a;
      a = adr | (16'($urandom) & mask);   // random unused bits
      @(posedge wb_clk) cpu_req_i <= build_req(1'b1, 2'b11, a);
      @(negedge wb_clk);
      check("dev_sel_o", 16'(dev_sel_o), sel);
      check("dat_o", dat_o, dat);
      check("cpu_ack_o", 16'(cpu_ack_o), 16'h1);
      @(posedge wb_clk) cpu_req_i <= build_req(1'b0, 2'b11, '0);
   endtask

   task automatic run_ram(input addr_t adr, input logic [15:0] mask,
                          input logic [15:0] sel, input logic [15:0] dat);
      int n;
      int cycles;
      @(posedge wb_clk) cpu_req_i <= build_req(1'b1, 2'b11, adr | (16'($urandom) & mask));
      n = 0;
      do begin
         @(negedge wb_clk);
         n++;
      end while (!ram_done_i && n < WAIT_LIMIT);
      if (!ram_done_i) timed_out("ram_done_i");
      check("dev_sel_o", 16'(dev_sel_o), sel);
      check("cpu_ack_o", 16'(cpu_ack_o), 16'h0);
      wait_ack(0, cycles);
      check("cpu_ack_o delay", 16'(cycles), 16'd2);
      check("dat_o", dat_o, dat);
      @(posedge wb_clk) cpu_req_i <= build_req(1'b0, 2'b11, '0);
   endtask

   task automatic run_dma(input addr_t adr, input logic [15:0] sel);
      int cycles;
      @(posedge wb_clk) begin
         rk_req_i <= build_req(1'b1, 2'b00, adr);
         my_req_i <= build_req(1'b1, 2'b00, adr + 16'h0100);
      end
      @(negedge wb_clk) check("rk_gnt_o", 16'(rk_gnt_o), 16'h0);
      @(negedge wb_clk);   // one cycle later
      check("rk_gnt_o", 16'(rk_gnt_o), 16'h1);
      check("my_gnt_o", 16'(my_gnt_o), 16'h0);
      check("cpu_gnt_o", 16'(cpu_gnt_o), 16'h0);
      check("bus_o.adr", bus_o.adr, adr);
      check("bus_o.sel", 16'(bus_o.sel), 16'h3);
      check("dev_sel_o", 16'(dev_sel_o), sel);
      wait_ack(1, cycles);
      @(posedge wb_clk) rk_req_i <= build_req(1'b0, 2'b00, '0);
      wait_gnt(2);
      check("bus_o.sel", 16'(bus_o.sel), 16'h3);
      wait_ack(2, cycles);
      @(posedge wb_clk) my_req_i <= build_req(1'b0, 2'b00, '0);
      wait_gnt(0);
   endtask

   task automatic run_dma_blocked(input addr_t adr);
      int n;
      @(posedge wb_clk) cpu_req_i <= build_req(1'b1, 2'b11, adr);
      @(posedge wb_clk) rk_req_i <= build_req(1'b1, 2'b00, adr);
      n = 0;
      do begin
         @(negedge wb_clk);
         n++;
         check("rk_gnt_o", 16'(rk_gnt_o), 16'h0);   // cpu cycle still open
      end while (!cpu_ack_o && n < WAIT_LIMIT);
      if (!cpu_ack_o) timed_out("cpu_ack_o");
      @(posedge wb_clk) cpu_req_i <= build_req(1'b0, 2'b11, '0);
      @(negedge wb_clk) check("rk_gnt_o", 16'(rk_gnt_o), 16'h0);
      @(negedge wb_clk) check("rk_gnt_o", 16'(rk_gnt_o), 16'h1);
      wait_ack(1, n);
      @(posedge wb_clk) rk_req_i <= build_req(1'b0, 2'b00, '0);
      wait_gnt(0);
   endtask

   // order holds the expected grants with the first in the top nibble
   task automatic run_sd(input logic [3:0] reqs, input logic [15:0] order);
      logic [3:0] g;
      @(posedge wb_clk) sd_req_i <= reqs;
      for (int k = 3; k >= 0; k--) begin
         g = order[k*4 +: 4];
         @(posedge wb_clk) sd_cs_i <= ~g;   // only the next owner pulls its cs low
         wait_sd(g, g);
         repeat (3) begin   // the others stay refused
            @(negedge wb_clk);
            check("sd_gnt_o", 16'(sd_gnt_o), 16'(g));
            check("sdcard_mosi_o", 16'(sdcard_mosi_o), 16'(|(sd_mosi_i & g)));
            check("sdcard_cs_o", 16'(sdcard_cs_o), 16'h0);
         end
         @(posedge wb_clk) sd_req_i <= sd_req_i & ~g;
         wait_sd(4'h0, g);
      end
      check("sdcard_mosi_o", 16'(sdcard_mosi_o), 16'(SD_IDLE_MOSI));
      check("sdcard_cs_o", 16'(sdcard_cs_o), 16'(SD_IDLE_CS));
      @(posedge wb_clk) sd_cs_i <= '1;
   endtask

   //****************************************
   // main sequence
   //****************************************
   initial begin
      int t;
      void'($urandom(43053));
      rst_n_i      = 1'b0;
      sysram_stb_i = 1'b0;
      cpu_req_i    = build_req(1'b0, 2'b11, '0);
      rk_req_i     = build_req(1'b0, 2'b00, '0);
      my_req_i     = build_req(1'b0, 2'b00, '0);
      sd_req_i     = '0;
      sd_cs_i      = '1;
      for (int i = 0; i < NUM_WORDS; i++) vec[i] = '0;   // op 0 ends the list
      $readmemh("testbench/backplane_tests.txt", vec);
      repeat (3) @(posedge wb_clk);
      rst_n_i <= 1'b1;
      @(negedge wb_clk);
      check("cpu_gnt_o", 16'(cpu_gnt_o), 16'h1);
      check("rk_gnt_o", 16'(rk_gnt_o), 16'h0);
      check("my_gnt_o", 16'(my_gnt_o), 16'h0);
      check("sd_gnt_o", 16'(sd_gnt_o), 16'h0);
      check("sdcard_cs_o", 16'(sdcard_cs_o), 16'h1);
      t = 0;
      while (t + 4 < NUM_WORDS && vec[t] != 16'h0) begin
         case (vec[t])
            16'h1: run_decode(vec[t+1], vec[t+2], vec[t+3], vec[t+4]);
            16'h2: run_ram(vec[t+1], vec[t+2], vec[t+3], vec[t+4]);
            16'h3: run_dma(vec[t+1], vec[t+3]);
            16'h4: run_dma_blocked(vec[t+1]);
            16'h5: run_sd(vec[t+1][3:0], vec[t+4]);
            default: begin
               errors++;
               $display("unknown operation code %h in test file", vec[t]);
            end
         endcase
         t += 5;
      end
      $display("tests run: %0d, errors: %0d", t / 5, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: wb_backplane.f
hdl/backplane_pkg.sv
hdl/bus_master_switch.sv
hdl/io_page_decoder.sv
hdl/slave_return.sv
hdl/sd_card_arbiter.sv
hdl/wb_backplane.sv
testbench/tb_wb_backplane.sv
